// File: project.f
pe_pkg.sv
inst_mem.sv
data_mem.sv
complex_alu.sv
pe.sv
tb_pe.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the PE testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f project.f --top-module tb_pe
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_pe)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "TEST OK"; then
    exit 0
fi
exit 1

// File: tb_pe.sv
`timescale 1ns/1ps
`default_nettype none

module tb_pe;

    localparam int          period    = 40;
    localparam int          num_tests = 6;
    localparam logic [31:0] seed      = 32'h308e_246a;

    logic                          clk;
    logic                          rst_n;
    logic                          din_pe_v, din_tx_v, inst_in_v, start;
    logic [pe_pkg::word_width-1:0] din_pe, din_tx;
    logic [pe_pkg::inst_width-1:0] inst_in;
    logic                          busy, dout_pe_v, dout_tx_v;
    logic [pe_pkg::word_width-1:0] dout_pe, dout_tx;

    logic [15:0] prog_q[$];                   // program to stream in
    logic [31:0] a_q[$], b_q[$];              // bank A / bank B operands
    logic [31:0] exp_tx[$], exp_pe[$];        // model results
    logic [31:0] got_tx[$], got_pe[$];        // captured DUT words
    int          got_t[$];                    // cycle of each dout_tx word
    int          cyc    = 0;
    int          errs   = 0;
    int          checks = 0;
    int          tests  = 0;
    logic [31:0] rnd;

    pe u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .din_pe_v  (din_pe_v),
        .din_pe    (din_pe),
        .din_tx_v  (din_tx_v),
        .din_tx    (din_tx),
        .inst_in_v (inst_in_v),
        .inst_in   (inst_in),
        .start     (start),
        .busy      (busy),
        .dout_pe_v (dout_pe_v),
        .dout_pe   (dout_pe),
        .dout_tx_v (dout_tx_v),
        .dout_tx   (dout_tx)
    );

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 1;

    // outputs only move on rising edges, so falling edge sampling is safe
    always @(negedge clk) begin
        if (dout_tx_v) begin
            got_tx.push_back(dout_tx);
            got_t.push_back(cyc);
        end
        if (dout_pe_v) got_pe.push_back(dout_pe);
    end

    initial begin
        #(period * 64 * num_tests);
        $display("watchdog: simulation ran past its time limit");
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reference model, {imag, real}, 16-bit wrap, products cut to 29:14
    ////////////////////////////////////////////////////////////////////////////

    function automatic logic [15:0] cut(input logic signed [15:0] x,
                                        input logic signed [15:0] y);
        logic signed [31:0] p;
        p = x * y;
        return p[29:14];  // upper bits just wrap
    endfunction

    function automatic logic [31:0] cmul(input logic [31:0] a, input logic [31:0] b);
        logic [15:0] re, im;
        re = cut(a[15:0], b[15:0]) - cut(a[31:16], b[31:16]);
        im = cut(a[15:0], b[31:16]) + cut(a[31:16], b[15:0]);
        return {im, re};
    endfunction

    function automatic logic [31:0] cadd(input logic [31:0] a, input logic [31:0] b);
        return {a[31:16] + b[31:16], a[15:0] + b[15:0]};
    endfunction

    function automatic logic [31:0] csub(input logic [31:0] a, input logic [31:0] b);
        return {a[31:16] - b[31:16], a[15:0] - b[15:0]};
    endfunction

    // op | dst | src_a | src_b | last | spare
    function automatic logic [15:0] enc(input logic [2:0] op, input int dst,
                                        input int sa, input int sb, input logic last);
        return {op, dst[2:0], sa[3:0], sb[3:0], last, 1'b0};
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // drive and check helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic clear_queues();
        prog_q.delete();
        a_q.delete();
        b_q.delete();
        exp_tx.delete();
        exp_pe.delete();
        got_tx.delete();
        got_pe.delete();
        got_t.delete();
    endtask

    // all three streaks side by side, each counter starts at 0
    task automatic load_all();
        int n;
        int i;
        n = prog_q.size();
        if (a_q.size() > n) n = a_q.size();
        if (b_q.size() > n) n = b_q.size();
        for (i = 0; i < n; i++) begin
            @(negedge clk);
            inst_in_v = (i < prog_q.size());
            din_pe_v  = (i < a_q.size());
            din_tx_v  = (i < b_q.size());
            if (inst_in_v) inst_in = prog_q[i];
            if (din_pe_v) din_pe = a_q[i];
            if (din_tx_v) din_tx = b_q[i];
        end
        @(negedge clk);
        inst_in_v = 1'b0;
        din_pe_v  = 1'b0;
        din_tx_v  = 1'b0;
    endtask

    // start pulse, optional second pulse while busy, then wait for HALT
    task automatic run_prog(input bit again, output int st);
        int guard;
        @(negedge clk);
        start = 1'b1;
        st    = cyc;
        @(negedge clk);
        start = 1'b0;
        if (again) begin
            @(negedge clk);
            start = 1'b1;  // must be ignored
            @(negedge clk);
            start = 1'b0;
        end
        guard = 0;
        while (busy && guard < 64) begin
            @(negedge clk);
            guard++;
        end
        if (busy) begin
            $display("busy never fell after HALT");
            errs++;
        end
        repeat (4) @(negedge clk);  // drain, last result lands 3 cycles after issue
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            $display("Fail %s: expected %h, actual %h", name, exp, act);
            errs++;
        end
    endtask

    task automatic check_results(input string name);
        int i;
        if (got_tx.size() != exp_tx.size()) begin
            $display("%s: dout_tx gave %0d words where %0d were expected",
                     name, got_tx.size(), exp_tx.size());
            errs++;
        end
        if (got_pe.size() != exp_pe.size()) begin
            $display("%s: dout_pe gave %0d words where %0d were expected",
                     name, got_pe.size(), exp_pe.size());
            errs++;
        end
        for (i = 0; i < exp_tx.size() && i < got_tx.size(); i++)
            check_value(name, exp_tx[i], got_tx[i]);  // order matters
        for (i = 0; i < exp_pe.size() && i < got_pe.size(); i++)
            check_value(name, exp_pe[i], got_pe[i]);
    endtask

    task automatic report(input string name, input int errs_before);
        tests++;
        $display("%s: %s", name, (errs == errs_before) ? "passed" : "failed");
    endtask

    // MUL then three MACs, running acc on each, last one is alpha
    task automatic setup_mac_chain();
        logic [31:0] a, b, acc;
        int i;
        for (i = 0; i < 4; i++) begin
            a = $urandom();
            b = $urandom();
            a_q.push_back(a);
            b_q.push_back(b);
            acc = (i == 0) ? cmul(a, b) : cadd(acc, cmul(a, b));
            prog_q.push_back(enc((i == 0) ? pe_pkg::op_mul : pe_pkg::op_mac,
                                 4 + i, i, 8 + i, i == 3));
            exp_tx.push_back(acc);
        end
        exp_pe.push_back(acc);
        prog_q.push_back(enc(pe_pkg::op_halt, 0, 0, 0, 1'b0));
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_add_sub();
        int e0, st;
        logic [31:0] a0, a1, b0, b1;
        e0 = errs;
        clear_queues();
        a0 = $urandom();
        a1 = $urandom();
        b0 = $urandom();
        b1 = $urandom();
        a_q.push_back(a0);
        a_q.push_back(a1);
        b_q.push_back(b0);
        b_q.push_back(b1);
        prog_q.push_back(enc(pe_pkg::op_add, 2, 0, 8, 1'b0));
        prog_q.push_back(enc(pe_pkg::op_sub, 3, 1, 9, 1'b0));
        prog_q.push_back(enc(pe_pkg::op_halt, 0, 0, 0, 1'b0));
        exp_tx.push_back(cadd(a0, b0));
        exp_tx.push_back(csub(a1, b1));
        load_all();
        run_prog(1'b0, st);
        check_results("test_add_sub");
        if (got_t.size() > 0) check_value("test_add_sub", 4, got_t[0] - st);
        report("test_add_sub", e0);
    endtask

    task automatic test_mul_random();
        int e0, st, i;
        logic [31:0] a, b;
        e0 = errs;
        clear_queues();
        for (i = 0; i < 4; i++) begin
            a = $urandom();
            b = $urandom();
            a_q.push_back(a);
            b_q.push_back(b);
            prog_q.push_back(enc(pe_pkg::op_mul, 4 + i, i, 8 + i, 1'b0));
            exp_tx.push_back(cmul(a, b));
        end
        prog_q.push_back(enc(pe_pkg::op_halt, 0, 0, 0, 1'b0));
        load_all();
        run_prog(1'b0, st);
        check_results("test_mul_random");
        report("test_mul_random", e0);
    endtask

    task automatic test_mac_chain();
        int e0, st;
        e0 = errs;
        clear_queues();
        setup_mac_chain();
        load_all();
        run_prog(1'b0, st);
        check_results("test_mac_chain");
        report("test_mac_chain", e0);
    endtask

    task automatic test_writeback();
        int e0, st;
        logic [31:0] a0, a1, b0, r;
        e0 = errs;
        clear_queues();
        a0 = $urandom();
        a1 = $urandom();
        b0 = $urandom();
        a_q.push_back(a0);
        a_q.push_back(a1);
        b_q.push_back(b0);
        prog_q.push_back(enc(pe_pkg::op_add, 2, 0, 8, 1'b0));
        repeat (3) prog_q.push_back(enc(pe_pkg::op_nop, 0, 0, 0, 1'b0));
        prog_q.push_back(enc(pe_pkg::op_add, 3, 2, 1, 1'b0));  // reads written-back word
        prog_q.push_back(enc(pe_pkg::op_halt, 0, 0, 0, 1'b0));
        r = cadd(a0, b0);
        exp_tx.push_back(r);
        exp_tx.push_back(cadd(r, a1));
        load_all();
        run_prog(1'b0, st);
        check_results("test_writeback");
        report("test_writeback", e0);
    endtask

    task automatic test_alpha_and_busy();
        int e0, st, i;
        logic [31:0] a, b;
        e0 = errs;
        clear_queues();
        for (i = 0; i < 3; i++) begin
            a = $urandom();
            b = $urandom();
            a_q.push_back(a);
            b_q.push_back(b);
            prog_q.push_back(enc((i == 1) ? pe_pkg::op_sub : pe_pkg::op_add,
                                 4 + i, i, 8 + i, i == 1));
            exp_tx.push_back((i == 1) ? csub(a, b) : cadd(a, b));
        end
        exp_pe.push_back(exp_tx[1]);  // only the middle one is alpha
        prog_q.push_back(enc(pe_pkg::op_halt, 0, 0, 0, 1'b0));
        load_all();
        run_prog(1'b1, st);
        check_results("test_alpha_and_busy");
        check_value("test_alpha_and_busy", 0, 32'(busy));  // no rerun from stale start
        report("test_alpha_and_busy", e0);
    endtask

    task automatic test_reset();
        int e0, st;
        e0 = errs;
        clear_queues();
        setup_mac_chain();
        prog_q[0] = prog_q[0] | (16'd1 << pe_pkg::last_bit);  // mul is alpha too
        exp_pe.push_front(exp_tx[0]);
        load_all();
        @(negedge clk);
        start = 1'b1;
        @(negedge clk);
        start = 1'b0;
        repeat (2) @(negedge clk);  // mid run, reset edge meets the first result
        rst_n = 1'b0;
        @(negedge clk);
        check_value("test_reset", 0, 32'(busy));
        check_value("test_reset", 0, 32'(dout_tx_v));
        check_value("test_reset", 0, 32'(dout_pe_v));
        @(negedge clk);  // second reset cycle
        rst_n = 1'b1;
        got_tx.delete();
        got_pe.delete();
        got_t.delete();
        run_prog(1'b0, st);  // operands untouched, dsts are 4..7
        check_results("test_reset");
        report("test_reset", e0);
    endtask

    initial begin
        rst_n     = 1'b0;
        start     = 1'b0;
        din_pe_v  = 1'b0;
        din_tx_v  = 1'b0;
        inst_in_v = 1'b0;
        din_pe    = '0;
        din_tx    = '0;
        inst_in   = '0;
        rnd       = $urandom(seed);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_add_sub();
        test_mul_random();
        test_mac_chain();
        test_writeback();
        test_alpha_and_busy();
        test_reset();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errs);
        if (errs == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: pe.sv
`timescale 1ns/1ps
`default_nettype none

module pe (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          din_pe_v,
    input  wire logic [pe_pkg::word_width-1:0] din_pe,
    input  wire logic                          din_tx_v,
    input  wire logic [pe_pkg::word_width-1:0] din_tx,
    input  wire logic                          inst_in_v,
    input  wire logic [pe_pkg::inst_width-1:0] inst_in,
    input  wire logic                          start,
    output logic                               busy,
    output logic                               dout_pe_v,
    output logic      [pe_pkg::word_width-1:0] dout_pe,
    output logic                               dout_tx_v,
    output logic      [pe_pkg::word_width-1:0] dout_tx
);

    logic                               inst_v;
    logic [pe_pkg::inst_width-1:0]      inst;
    logic [pe_pkg::word_width-1:0]      rd_a, rd_b;
    logic                               res_v;
    logic [pe_pkg::word_width-1:0]      res;
    logic [pe_pkg::bank_addr_width-1:0] res_dst;
    logic                               alpha_v;

    ////////////////////////////////////////////////////////////////////////////
    // start -> issue -> read -> product -> result, 4 cycles to first res
    ////////////////////////////////////////////////////////////////////////////

    inst_mem u_imem (
        .clk       (clk),
        .rst_n     (rst_n),
        .inst_in_v (inst_in_v),
        .inst_in   (inst_in),
        .start     (start),
        .inst_v    (inst_v),
        .inst      (inst),
        .busy      (busy)
    );

    data_mem u_dmem (
        .clk      (clk),
        .rst_n    (rst_n),
        .din_ld_v (din_pe_v),   // local operands -> bank A
        .din_ld   (din_pe),
        .din_tx_v (din_tx_v),   // upstream operands -> bank B
        .din_tx   (din_tx),
        .inst_v   (inst_v),
        .inst     (inst),
        .wb_v     (res_v),      // every result lands in bank A
        .wb_addr  (res_dst),
        .wb_data  (res),
        .rd_a     (rd_a),
        .rd_b     (rd_b)
    );

    complex_alu u_alu (
        .clk     (clk),
        .rst_n   (rst_n),
        .inst_v  (inst_v),
        .inst    (inst),
        .rd_a    (rd_a),
        .rd_b    (rd_b),
        .res_v   (res_v),
        .res     (res),
        .res_dst (res_dst),
        .alpha_v (alpha_v)
    );

    // every result goes downstream, only last ones count as alpha
    assign dout_tx_v = res_v;
    assign dout_tx   = res;
    assign dout_pe_v = alpha_v;
    assign dout_pe   = res;

endmodule

`default_nettype wire

// File: complex_alu.sv
`timescale 1ns/1ps
`default_nettype none

module complex_alu (
    input  wire logic                               clk,
    input  wire logic                               rst_n,
    input  wire logic                               inst_v,
    input  wire logic [pe_pkg::inst_width-1:0]      inst,
    input  wire logic [pe_pkg::word_width-1:0]      rd_a,
    input  wire logic [pe_pkg::word_width-1:0]      rd_b,
    output logic                                    res_v,
    output logic      [pe_pkg::word_width-1:0]      res,
    output logic      [pe_pkg::bank_addr_width-1:0] res_dst,
    output logic                                    alpha_v
);

    localparam int dw = pe_pkg::data_width;
    localparam int fb = pe_pkg::frac_bits;

    // operand stage, instruction held one cycle to meet the read data
    logic                          inst_v_d;
    logic [pe_pkg::inst_width-1:0] inst_d;
    pe_pkg::opcode_e               op_d;
    logic signed [dw-1:0]          a_re, a_im, b_re, b_im;
    logic signed [2*dw-1:0]        m_rr, m_ii, m_ri, m_ir;   // full products

    // product stage
    logic                               v_p;
    pe_pkg::opcode_e                    op_p;
    logic [pe_pkg::bank_addr_width-1:0] dst_p;
    logic                               last_p;
    logic [dw-1:0]                      pp_rr, pp_ii, pp_ri, pp_ir;  // scaled
    logic [dw-1:0]                      as_re, as_im;                // add/sub

    // result stage
    logic [dw-1:0] acc_re, acc_im;
    logic [dw-1:0] prod_re, prod_im;
    logic [dw-1:0] mac_re, mac_im;
    logic          is_arith;

    assign op_d = pe_pkg::opcode_e'(inst_d[pe_pkg::op_msb -: pe_pkg::op_width]);
    assign a_re = rd_a[dw-1:0];
    assign a_im = rd_a[2*dw-1:dw];
    assign b_re = rd_b[dw-1:0];
    assign b_im = rd_b[2*dw-1:dw];
    assign m_rr = a_re * b_re;
    assign m_ii = a_im * b_im;
    assign m_ri = a_re * b_im;
    assign m_ir = a_im * b_re;

    // part products already cut, combine wraps at 16 bits
    assign prod_re  = pp_rr - pp_ii;
    assign prod_im  = pp_ri + pp_ir;
    assign mac_re   = acc_re + prod_re;
    assign mac_im   = acc_im + prod_im;
    assign is_arith = op_p inside {pe_pkg::op_add, pe_pkg::op_sub,
                                   pe_pkg::op_mul, pe_pkg::op_mac};

    ////////////////////////////////////////////////////////////////////////////
    // control and accumulator
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            inst_v_d <= 1'b0;
            v_p      <= 1'b0;
            res_v    <= 1'b0;
            alpha_v  <= 1'b0;
            acc_re   <= '0;
            acc_im   <= '0;
        end else begin
            inst_v_d <= inst_v;
            v_p      <= inst_v_d;
            res_v    <= v_p & is_arith;          // nop gives nothing
            alpha_v  <= v_p & is_arith & last_p;
            if (v_p && op_p == pe_pkg::op_mul) begin
                acc_re <= prod_re;               // fresh sum
                acc_im <= prod_im;
            end else if (v_p && op_p == pe_pkg::op_mac) begin
                acc_re <= mac_re;                // overflow wraps
                acc_im <= mac_im;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // datapath
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        inst_d <= inst;
        op_p   <= op_d;
        dst_p  <= inst_d[pe_pkg::dst_msb -: pe_pkg::bank_addr_width];
        last_p <= inst_d[pe_pkg::last_bit];
        pp_rr  <= m_rr[fb+dw-1:fb];  // bits 29:14
        pp_ii  <= m_ii[fb+dw-1:fb];
        pp_ri  <= m_ri[fb+dw-1:fb];
        pp_ir  <= m_ir[fb+dw-1:fb];
        if (op_d == pe_pkg::op_sub) begin
            as_re <= a_re - b_re;
            as_im <= a_im - b_im;
        end else begin
            as_re <= a_re + b_re;
            as_im <= a_im + b_im;
        end
        res_dst <= dst_p;
        case (op_p)
            pe_pkg::op_mul: res <= {prod_im, prod_re};
            pe_pkg::op_mac: res <= {mac_im, mac_re};   // new acc value
            default:        res <= {as_im, as_re};
        endcase
    end

    // issue never hands over a halt or an undefined opcode
    a_known_opcode: assert property (@(posedge clk) disable iff (!rst_n)
        inst_v |-> inst[pe_pkg::op_msb -: pe_pkg::op_width] inside {pe_pkg::op_nop,
            pe_pkg::op_add, pe_pkg::op_sub, pe_pkg::op_mul, pe_pkg::op_mac})
        else $error("complex_alu: issued opcode is not an ALU operation");

endmodule

`default_nettype wire

// File: data_mem.sv
`timescale 1ns/1ps
`default_nettype none

module data_mem (
    input  wire logic                                clk,
    input  wire logic                                rst_n,
    input  wire logic                                din_ld_v,
    input  wire logic [pe_pkg::word_width-1:0]       din_ld,
    input  wire logic                                din_tx_v,
    input  wire logic [pe_pkg::word_width-1:0]       din_tx,
    input  wire logic                                inst_v,
    input  wire logic [pe_pkg::inst_width-1:0]       inst,
    input  wire logic                                wb_v,
    input  wire logic [pe_pkg::bank_addr_width-1:0]  wb_addr,
    input  wire logic [pe_pkg::word_width-1:0]       wb_data,
    output logic      [pe_pkg::word_width-1:0]       rd_a,
    output logic      [pe_pkg::word_width-1:0]       rd_b
);

    localparam int mem_words = 2 ** pe_pkg::addr_width;

    logic [pe_pkg::word_width-1:0]      mem [mem_words];
    logic [pe_pkg::bank_addr_width-1:0] ld_a_cnt;  // local operand pointer
    logic [pe_pkg::bank_addr_width-1:0] ld_b_cnt;  // forwarded operand pointer
    logic [pe_pkg::addr_width-1:0]      src_a;
    logic [pe_pkg::addr_width-1:0]      src_b;

    assign src_a = inst[pe_pkg::srca_msb -: pe_pkg::addr_width];
    assign src_b = inst[pe_pkg::srcb_msb -: pe_pkg::addr_width];

    ////////////////////////////////////////////////////////////////////////////
    // load pointers, restart at 0 after each streak
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ld_a_cnt <= '0;
            ld_b_cnt <= '0;
        end else begin
            if (din_ld_v) begin
                ld_a_cnt <= ld_a_cnt + 1'b1;  // wraps after bank_words
            end else begin
                ld_a_cnt <= '0;
            end
            if (din_tx_v) begin
                ld_b_cnt <= ld_b_cnt + 1'b1;
            end else begin
                ld_b_cnt <= '0;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // storage, two write ports and two read ports
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        // bank A port, write-back takes it over a host load
        if (wb_v) begin
            mem[{1'b0, wb_addr}] <= wb_data;
        end else if (din_ld_v) begin
            mem[{1'b0, ld_a_cnt}] <= din_ld;
        end
        // bank B port, fed by the upstream PE
        if (din_tx_v) begin
            mem[{1'b1, ld_b_cnt}] <= din_tx;
        end
        // reads see the value before this edge's writes
        if (inst_v) begin
            rd_a <= mem[src_a];
            rd_b <= mem[src_b];
        end
    end

    // host loads bank A only while no program writes back
    a_no_ld_wb_clash: assert property (@(posedge clk) disable iff (!rst_n)
        !(din_ld_v && wb_v))
        else $error("data_mem: local load collides with write-back");

endmodule

`default_nettype wire

// File: inst_mem.sv
`timescale 1ns/1ps
`default_nettype none

module inst_mem (
    input  wire logic                          clk,
    input  wire logic                          rst_n,
    input  wire logic                          inst_in_v,
    input  wire logic [pe_pkg::inst_width-1:0] inst_in,
    input  wire logic                          start,
    output logic                               inst_v,
    output logic      [pe_pkg::inst_width-1:0] inst,
    output logic                               busy
);

    logic [pe_pkg::inst_width-1:0] prog [pe_pkg::imem_depth];
    logic [pe_pkg::pc_width-1:0]   ld_cnt;     // host load pointer
    logic [pe_pkg::pc_width-1:0]   pc;         // next fetch address
    logic [pe_pkg::pc_width-1:0]   fetch_addr;
    logic [pe_pkg::inst_width-1:0] fetch_word;
    logic                          run;
    logic                          is_halt;

    ////////////////////////////////////////////////////////////////////////////
    // program load, one word per strobe
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (inst_in_v) begin
            prog[ld_cnt] <= inst_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ld_cnt <= '0;
        end else if (inst_in_v) begin
            ld_cnt <= ld_cnt + 1'b1;  // wraps past depth
        end else begin
            ld_cnt <= '0;             // streak over
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // issue
    ////////////////////////////////////////////////////////////////////////////

    // start while idle fetches word 0 straight away, start while busy is moot
    assign run        = busy | start;
    assign fetch_addr = busy ? pc : '0;
    assign fetch_word = prog[fetch_addr];
    assign is_halt    = pe_pkg::opcode_e'(fetch_word[pe_pkg::op_msb -: pe_pkg::op_width])
                        == pe_pkg::op_halt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy   <= 1'b0;
            inst_v <= 1'b0;
            pc     <= '0;
        end else begin
            inst_v <= run & ~is_halt;            // halt itself is not issued
            if (run && !is_halt) begin
                busy <= 1'b1;
                pc   <= fetch_addr + 1'b1;
            end else if (run) begin
                busy <= 1'b0;                    // halt seen, stop
                pc   <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        inst <= fetch_word;  // payload only
    end

    // host must not rewrite the program under a running pc
    a_no_load_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
        busy |-> !inst_in_v)
        else $error("inst_mem: program load while busy");

endmodule

`default_nettype wire

// File: pe_pkg.sv
`default_nettype none

package pe_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // data format
    ////////////////////////////////////////////////////////////////////////////

    localparam int data_width = 16;             // one real or imag part
    localparam int word_width = 2 * data_width; // {imag, real}
    localparam int frac_bits  = 14;             // fixed point fraction

    // operand memory, bank A low half, bank B high half
    localparam int bank_words      = 8;
    localparam int bank_addr_width = $clog2(bank_words);
    localparam int addr_width      = bank_addr_width + 1; // top bit picks bank

    // program store
    localparam int imem_depth = 16;
    localparam int pc_width   = $clog2(imem_depth);

    ////////////////////////////////////////////////////////////////////////////
    // instruction word
    ////////////////////////////////////////////////////////////////////////////

    localparam int inst_width = 16;
    localparam int op_width   = 3;

    // field msbs, top down: op | dst | src_a | src_b | last | spare
    localparam int op_msb   = inst_width - 1;        // 15:13
    localparam int dst_msb  = op_msb - op_width;     // 12:10, bank A only
    localparam int srca_msb = dst_msb - bank_addr_width;  // 9:6
    localparam int srcb_msb = srca_msb - addr_width; // 5:2
    localparam int last_bit = srcb_msb - addr_width; // 1, bit 0 is spare

    typedef enum logic [op_width-1:0] {
        op_nop  = 3'd0,  // slot filler, no result
        op_add  = 3'd1,
        op_sub  = 3'd2,
        op_mul  = 3'd3,  // also loads accumulator
        op_mac  = 3'd4,  // acc += a * b
        op_halt = 3'd5   // ends the run, never issued
    } opcode_e;

endpackage

`default_nettype wire
